/* sim.f */
hw/csr_pkg.sv
hw/csr_op_unit.sv
hw/trap_unit.sv
hw/irq_unit.sv
hw/csr_write_arbiter.sv
hw/machine_csr_regs.sv
hw/csr_bank_top.sv
verif/csr_bank_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the CSR bank testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/100ps -f sim.f \
        --top-module csr_bank_tb -o csr_bank_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! output=$(./obj_dir/csr_bank_sim 2>&1); then
    printf '%s\n' "$output"
    echo "Simulation exited with an error status"
    exit 1
fi
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Test passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* verif/csr_bank_tb.sv */
// Self-checking testbench; shadow model follows the mask and trap rules, watchdog bounds run time
`default_nettype none

module csr_bank_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RANDOM_OPS  = 400;
    localparam int TEST_CYCLES = RANDOM_OPS + 220;
    localparam int CLK_PERIOD  = 4;

    // Every mapped address plus two unmapped ones
    localparam csr_pkg::csr_addr_t ADDR_LIST [24] = '{
        csr_pkg::MSTATUS, csr_pkg::MISA, csr_pkg::MIE, csr_pkg::MTVEC,
        csr_pkg::MSCRATCH, csr_pkg::MEPC, csr_pkg::MCAUSE, csr_pkg::MTVAL,
        csr_pkg::MIP, csr_pkg::MCYCLE, csr_pkg::MCYCLEH, csr_pkg::MINSTRET,
        csr_pkg::MINSTRETH, csr_pkg::CYCLE, csr_pkg::CYCLEH, csr_pkg::INSTRET,
        csr_pkg::INSTRETH, csr_pkg::MVENDORID, csr_pkg::MARCHID, csr_pkg::MIMPID,
        csr_pkg::MHARTID, csr_pkg::MCONFIGPTR, 12'h7C0, 12'h302
    };
    localparam csr_pkg::exc_code_e EXC_LIST [5] = '{
        csr_pkg::ILLEGAL_INSTRUCTION, csr_pkg::BREAKPOINT,
        csr_pkg::ECALL_FROM_MMODE, csr_pkg::LOAD_ACCESS_FAULT,
        csr_pkg::ECALL_FROM_UMODE
    };

    logic               clk;
    logic               reset;
    csr_pkg::csr_req_t  csr_req;
    csr_pkg::trap_req_t trap_req;
    logic               killed;
    csr_pkg::csr_word_t irq;
    csr_pkg::csr_word_t read_data;
    logic               pending;
    csr_pkg::priv_e     privilege;
    csr_pkg::csr_word_t mtvec;
    csr_pkg::csr_word_t mepc;
    integer             seed;

    // Shadow registers of the reference model
    csr_pkg::csr_word_t  m_mstatus;
    csr_pkg::csr_word_t  m_misa;
    csr_pkg::csr_word_t  m_mie;
    csr_pkg::csr_word_t  m_mip;
    csr_pkg::csr_word_t  m_mtvec;
    csr_pkg::csr_word_t  m_mscratch;
    csr_pkg::csr_word_t  m_mepc;
    csr_pkg::csr_word_t  m_mcause;
    csr_pkg::csr_word_t  m_mtval;
    csr_pkg::csr_count_t m_mcycle;
    csr_pkg::csr_count_t m_minstret;
    csr_pkg::priv_e      m_priv;
    logic                m_pending;
    csr_pkg::irq_code_e  m_cause;

    csr_bank_top DUT (
        .clk                 (clk),
        .reset               (reset),
        .csr_req_i           (csr_req),
        .trap_req_i          (trap_req),
        .killed_i            (killed),
        .irq_i               (irq),
        .read_data_o         (read_data),
        .interrupt_pending_o (pending),
        .privilege_o         (privilege),
        .mtvec_o             (mtvec),
        .mepc_o              (mepc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic csr_pkg::csr_word_t ref_mask(input csr_pkg::csr_addr_t addr);
        case (addr)
            csr_pkg::MSTATUS:                   return 32'h007E19AA;
            csr_pkg::MISA:                      return 32'h3C000000;
            csr_pkg::MIE:                       return 32'h00000888;
            csr_pkg::MTVEC, csr_pkg::MEPC:      return 32'hFFFFFFFC;
            csr_pkg::MSCRATCH, csr_pkg::MCAUSE, csr_pkg::MTVAL, csr_pkg::MCYCLE,
            csr_pkg::MCYCLEH, csr_pkg::MINSTRET, csr_pkg::MINSTRETH: return 32'hFFFFFFFF;
            default:                            return 32'h0;
        endcase
    endfunction

    function automatic csr_pkg::csr_word_t ref_read(input csr_pkg::csr_addr_t addr);
        case (addr)
            csr_pkg::MSTATUS:                      return m_mstatus;
            csr_pkg::MISA:                         return m_misa;
            csr_pkg::MIE:                          return m_mie;
            csr_pkg::MTVEC:                        return m_mtvec;
            csr_pkg::MSCRATCH:                     return m_mscratch;
            csr_pkg::MEPC:                         return m_mepc;
            csr_pkg::MCAUSE:                       return m_mcause;
            csr_pkg::MTVAL:                        return m_mtval;
            csr_pkg::MIP:                          return m_mip;
            csr_pkg::MCYCLE, csr_pkg::CYCLE:       return m_mcycle[31:0];
            csr_pkg::MCYCLEH, csr_pkg::CYCLEH:     return m_mcycle[63:32];
            csr_pkg::MINSTRET, csr_pkg::INSTRET:   return m_minstret[31:0];
            csr_pkg::MINSTRETH, csr_pkg::INSTRETH: return m_minstret[63:32];
            default:                               return 32'h0;  // Identity and unmapped
        endcase
    endfunction

    // Expected read_data_o for the request on the bus this cycle
    function automatic csr_pkg::csr_word_t expected_read();
        return (csr_req.read_en && !killed) ? ref_read(csr_req.addr) : 32'h0;
    endfunction

    function automatic csr_pkg::csr_word_t ref_result(input csr_pkg::csr_op_e op,
                                                     input csr_pkg::csr_word_t cur,
                                                     input csr_pkg::csr_word_t data,
                                                     input csr_pkg::csr_word_t mask);
        case (op)
            csr_pkg::SET:   return (cur | data) & mask;
            csr_pkg::CLEAR: return (cur & ~data) & mask;
            default:        return data & mask;
        endcase
    endfunction

    // Reference model update for one clock edge using pre-edge state
    task automatic model_edge();
        csr_pkg::csr_word_t active;
        csr_pkg::csr_word_t entry;
        csr_pkg::csr_word_t wval;
        csr_pkg::exc_code_e code;
        logic               take;
        logic               at_pc;
        if (reset) begin
            {m_mstatus, m_mie, m_mip, m_mtvec, m_mscratch} = '0;
            {m_mepc, m_mcause, m_mtval, m_mcycle, m_minstret} = '0;
            m_misa    = 32'h40000100;
            m_priv    = csr_pkg::PRIV_MACHINE;
            m_pending = 1'b0;
            m_cause   = csr_pkg::M_EXT_INT;
        end else begin
            active = m_mie & m_mip;
            take   = m_mstatus[3] && (active != 32'h0) && !trap_req.interrupt_ack;
            wval   = ref_result(csr_req.op, ref_read(csr_req.addr), csr_req.data,
                                ref_mask(csr_req.addr));
            code   = trap_req.exception_code;
            at_pc  = (code == csr_pkg::ECALL_FROM_MMODE) || (code == csr_pkg::ECALL_FROM_UMODE)
                     || (code == csr_pkg::BREAKPOINT);
            entry  = m_mstatus;
            entry[12:11] = m_priv;  // MPP
            entry[7] = m_mstatus[3];
            entry[3] = 1'b0;
            m_mcycle = m_mcycle + 64'd1;
            if (!killed) begin
                m_minstret = m_minstret + 64'd1;
            end
            if (trap_req.machine_return) begin
                m_mstatus[3] = m_mstatus[7];
                m_priv = csr_pkg::priv_e'(m_mstatus[12:11]);
            end else if (trap_req.raise_exception) begin
                m_mstatus = entry;
                m_priv    = csr_pkg::PRIV_MACHINE;
                m_mepc    = at_pc ? trap_req.pc : trap_req.pc + 32'd4;
                m_mcause  = {27'b0, code};
                m_mtval   = (code == csr_pkg::ILLEGAL_INSTRUCTION)
                            ? trap_req.instruction : trap_req.pc;
            end else if (trap_req.interrupt_ack) begin
                m_mstatus = entry;
                m_priv    = csr_pkg::PRIV_MACHINE;
                m_mepc    = trap_req.jump ? trap_req.jump_target : trap_req.pc;
                m_mcause  = {1'b1, 26'b0, m_cause};
            end else if (csr_req.write_en && !killed && csr_req.op != csr_pkg::NONE) begin
                case (csr_req.addr)
                    csr_pkg::MSTATUS:   m_mstatus = wval;
                    csr_pkg::MISA:      m_misa = wval;
                    csr_pkg::MIE:       m_mie = wval;
                    csr_pkg::MTVEC:     m_mtvec = wval;
                    csr_pkg::MSCRATCH:  m_mscratch = wval;
                    csr_pkg::MEPC:      m_mepc = wval;
                    csr_pkg::MCAUSE:    m_mcause = wval;
                    csr_pkg::MTVAL:     m_mtval = wval;
                    csr_pkg::MCYCLE:    m_mcycle[31:0] = wval;
                    csr_pkg::MCYCLEH:   m_mcycle[63:32] = wval;
                    csr_pkg::MINSTRET:  m_minstret[31:0] = wval;
                    csr_pkg::MINSTRETH: m_minstret[63:32] = wval;
                    default: ;
                endcase
            end
            if (take) begin
                if (active[11]) m_cause = csr_pkg::M_EXT_INT;  // External first
                else if (active[3]) m_cause = csr_pkg::M_SW_INT;
                else if (active[7]) m_cause = csr_pkg::M_TIM_INT;
            end
            m_pending = take;
            m_mip     = irq;
        end
    endtask

    always @(posedge clk) model_edge();

    task automatic check_value(input string name, input csr_pkg::csr_word_t actual,
                               input csr_pkg::csr_word_t expected);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s: actual %h expected %h", $time, name, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // Compare at the falling edge, between drive and the next rising edge
    always @(negedge clk) begin
        if (!reset) begin
            check_value("read_data_o", read_data, expected_read());
            check_value("privilege_o", {30'b0, privilege}, {30'b0, m_priv});
            check_value("mtvec_o", mtvec, m_mtvec);
            check_value("mepc_o", mepc, m_mepc);
            check_value("interrupt_pending_o", {31'b0, pending}, {31'b0, m_pending});
        end
    end

    initial begin
        #(TEST_CYCLES * CLK_PERIOD + 400);
        $display("Run timed out before the test sequence completed");
        $display("Test failed");
        $fatal(1);
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // Holds one request for a cycle, together with whatever trap_req was set up
    task automatic csr_cycle(input logic rd, input logic wr, input csr_pkg::csr_op_e op,
                             input csr_pkg::csr_addr_t addr, input csr_pkg::csr_word_t data,
                             input logic kill);
        csr_req = '{read_en: rd, write_en: wr, op: op, addr: addr, data: data};
        killed  = kill;
        tick();
        csr_req  = '0;
        trap_req = '0;
        killed   = 1'b0;
    endtask

    task automatic read_csr(input csr_pkg::csr_addr_t addr);
        csr_cycle(1'b1, 1'b0, csr_pkg::NONE, addr, 32'h0, 1'b0);
    endtask

    task automatic sample_csr(input csr_pkg::csr_addr_t addr, output csr_pkg::csr_word_t value);
        csr_req = '{read_en: 1'b1, write_en: 1'b0, op: csr_pkg::NONE, addr: addr, data: '0};
        #1;
        value = read_data;
        tick();
    endtask

    task automatic wait_pending();
        int n;
        n = 0;
        while (!pending && n < 8) begin
            read_csr(csr_pkg::MIP);
            n++;
        end
        if (!pending) begin
            $display("Interrupt pending flag never rose after the request");
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // Request, re-enable through mret, wait, then acknowledge
    task automatic take_interrupt(input csr_pkg::csr_word_t bits, input logic jump);
        irq = bits;
        read_csr(csr_pkg::MIP);
        read_csr(csr_pkg::MIP);
        trap_req.machine_return = 1'b1;
        read_csr(csr_pkg::MSTATUS);
        wait_pending();
        trap_req.interrupt_ack = 1'b1;
        trap_req.pc            = $random(seed);
        trap_req.jump          = jump;
        trap_req.jump_target   = $random(seed);
        read_csr(csr_pkg::MCAUSE);
        read_csr(csr_pkg::MCAUSE);
        read_csr(csr_pkg::MEPC);
    endtask

    initial begin
        csr_pkg::csr_word_t r;
        csr_pkg::csr_word_t c0;
        csr_pkg::csr_word_t c1;
        int                 idx;
        seed     = 32'h28b46836;
        clk      = 1'b0;
        reset    = 1'b1;
        csr_req  = '0;
        trap_req = '0;
        killed   = 1'b0;
        irq      = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int i = 0; i < 24; i++) read_csr(ADDR_LIST[i]);  // Reset values

        for (int i = 0; i < RANDOM_OPS; i++) begin
            r   = $random(seed);
            idx = int'(r[4:0]) % 24;
            irq = $random(seed) & 32'h888;
            csr_cycle(r[5], r[6] | r[7], csr_pkg::csr_op_e'(r[9:8]), ADDR_LIST[idx],
                      $random(seed), r[11:10] == 2'b00);
        end
        irq = '0;
        csr_cycle(1'b0, 1'b1, csr_pkg::WRITE, csr_pkg::MSCRATCH, 32'hA5A5_5A5A, 1'b1);
        csr_cycle(1'b1, 1'b0, csr_pkg::NONE, csr_pkg::MSCRATCH, 32'h0, 1'b1);
        read_csr(csr_pkg::MSCRATCH);

        // Exceptions racing a CSR write, each followed by mret
        for (int i = 0; i < 8; i++) begin
            trap_req.raise_exception = 1'b1;
            trap_req.exception_code  = EXC_LIST[i % 5];
            trap_req.pc              = $random(seed);
            trap_req.instruction     = $random(seed);
            csr_cycle(1'b1, 1'b1, csr_pkg::WRITE, csr_pkg::MSCRATCH, $random(seed), 1'b0);
            read_csr(csr_pkg::MCAUSE);
            read_csr(csr_pkg::MTVAL);
            read_csr(csr_pkg::MSCRATCH);
            trap_req.machine_return = 1'b1;
            read_csr(csr_pkg::MSTATUS);
            read_csr(csr_pkg::MSTATUS);
        end

        // Down to user mode and back through a trap
        csr_cycle(1'b0, 1'b1, csr_pkg::WRITE, csr_pkg::MSTATUS, 32'h0000_0080, 1'b0);
        trap_req.machine_return = 1'b1;
        read_csr(csr_pkg::MSTATUS);
        trap_req.raise_exception = 1'b1;
        trap_req.exception_code  = csr_pkg::BREAKPOINT;
        trap_req.pc              = 32'h0000_1000;
        read_csr(csr_pkg::MSTATUS);
        read_csr(csr_pkg::MSTATUS);
        trap_req.machine_return = 1'b1;
        read_csr(csr_pkg::MSTATUS);

        // Interrupts; priority external, software, timer
        csr_cycle(1'b0, 1'b1, csr_pkg::WRITE, csr_pkg::MIE, 32'h0000_0888, 1'b0);
        csr_cycle(1'b0, 1'b1, csr_pkg::WRITE, csr_pkg::MSTATUS, 32'h0000_1880, 1'b0);
        take_interrupt(32'h0000_0888, 1'b1);
        take_interrupt(32'h0000_0088, 1'b0);
        take_interrupt(32'h0000_0080, 1'b1);
        irq = '0;
        read_csr(csr_pkg::MIP);

        // Counters
        sample_csr(csr_pkg::MCYCLE, c0);
        repeat (9) read_csr(csr_pkg::CYCLE);
        sample_csr(csr_pkg::MCYCLE, c1);
        check_value("mcycle delta", c1 - c0, 32'd10);
        for (int i = 0; i < 16; i++) begin
            r = $random(seed);
            csr_cycle(1'b1, 1'b0, csr_pkg::NONE, csr_pkg::MINSTRET, 32'h0, r[0]);
        end
        csr_cycle(1'b0, 1'b1, csr_pkg::WRITE, csr_pkg::MCYCLE, 32'hFFFF_FFFD, 1'b0);
        repeat (4) read_csr(csr_pkg::MCYCLE);
        read_csr(csr_pkg::MCYCLEH);
        csr_cycle(1'b0, 1'b1, csr_pkg::WRITE, csr_pkg::MINSTRETH, 32'h1234_5678, 1'b0);
        csr_cycle(1'b0, 1'b1, csr_pkg::WRITE, csr_pkg::MINSTRET, 32'hFFFF_FFFF, 1'b0);
        read_csr(csr_pkg::INSTRET);
        read_csr(csr_pkg::INSTRETH);

        @(negedge clk);
        #1;
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/csr_bank_top.sv */
// CSR bank top; reads are combinational, no back-pressure, one update per cycle
`default_nettype none

module csr_bank_top (
    input  logic                clk,
    input  logic                reset,
    input  csr_pkg::csr_req_t   csr_req_i,
    input  csr_pkg::trap_req_t  trap_req_i,
    input  logic                killed_i,
    input  csr_pkg::csr_word_t  irq_i,
    output csr_pkg::csr_word_t  read_data_o,
    output logic                interrupt_pending_o,
    output csr_pkg::priv_e      privilege_o,
    output csr_pkg::csr_word_t  mtvec_o,
    output csr_pkg::csr_word_t  mepc_o
);

    csr_pkg::csr_state_t   state;
    csr_pkg::csr_write_t   csr_write;
    csr_pkg::csr_write_t   granted_write;
    csr_pkg::trap_update_t trap_update;
    csr_pkg::trap_update_t granted_update;
    csr_pkg::irq_code_e    irq_cause;
    csr_pkg::csr_word_t    mip;
    logic                  grant_trap;

    csr_op_unit u_op (
        .csr_req_i   (csr_req_i),
        .killed_i    (killed_i),
        .state_i     (state),
        .csr_write_o (csr_write),
        .read_data_o (read_data_o)
    );

    trap_unit u_trap (
        .trap_req_i    (trap_req_i),
        .irq_cause_i   (irq_cause),
        .state_i       (state),
        .trap_update_o (trap_update)
    );

    irq_unit u_irq (
        .clk             (clk),
        .reset           (reset),
        .irq_i           (irq_i),
        .interrupt_ack_i (trap_req_i.interrupt_ack),
        .state_i         (state),
        .mip_o           (mip),
        .irq_pending_o   (interrupt_pending_o),
        .irq_cause_o     (irq_cause)
    );

    csr_write_arbiter u_arb (
        .csr_write_i   (csr_write),
        .trap_update_i (trap_update),
        .grant_trap_o  (grant_trap),
        .update_o      (granted_update),
        .write_o       (granted_write)
    );

    machine_csr_regs u_regs (
        .clk          (clk),
        .reset        (reset),
        .killed_i     (killed_i),
        .mip_i        (mip),
        .grant_trap_i (grant_trap),
        .update_i     (granted_update),
        .write_i      (granted_write),
        .state_o      (state)
    );

    assign privilege_o = state.priv;
    assign mtvec_o     = state.mtvec;
    assign mepc_o      = state.mepc;

endmodule

`default_nettype wire

/* hw/machine_csr_regs.sv */
// Single-hart CSR storage; privilege resets to machine mode, mip is owned by the IRQ unit
`default_nettype none

module machine_csr_regs (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  killed_i,
    input  csr_pkg::csr_word_t    mip_i,
    input  logic                  grant_trap_i,
    input  csr_pkg::trap_update_t update_i,
    input  csr_pkg::csr_write_t   write_i,
    output csr_pkg::csr_state_t   state_o
);

    csr_pkg::csr_word_t  mstatus;
    csr_pkg::csr_word_t  misa;
    csr_pkg::csr_word_t  mie;
    csr_pkg::csr_word_t  mtvec;
    csr_pkg::csr_word_t  mscratch;
    csr_pkg::csr_word_t  mepc;
    csr_pkg::csr_word_t  mcause;
    csr_pkg::csr_word_t  mtval;
    csr_pkg::csr_count_t mcycle;
    csr_pkg::csr_count_t minstret;
    csr_pkg::priv_e      priv;

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus  <= '0;
            misa     <= csr_pkg::MISA_RESET;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            mcycle   <= '0;
            minstret <= '0;
            priv     <= csr_pkg::PRIV_MACHINE;
        end else begin
            mcycle <= mcycle + 64'd1;
            if (!killed_i) begin
                minstret <= minstret + 64'd1;  // Retired slots only
            end

            if (grant_trap_i) begin
                mstatus <= update_i.mstatus;
                priv    <= update_i.priv;
                if (update_i.load_mepc) begin
                    mepc <= update_i.mepc;
                end
                if (update_i.load_mcause) begin
                    mcause <= update_i.mcause;
                end
                if (update_i.load_mtval) begin
                    mtval <= update_i.mtval;
                end
            end else if (write_i.valid) begin
                // Counter half writes come later and take over that half's increment
                case (csr_pkg::csr_addr_e'(write_i.addr))
                    csr_pkg::MSTATUS:   mstatus         <= write_i.data;
                    csr_pkg::MISA:      misa            <= write_i.data;
                    csr_pkg::MIE:       mie             <= write_i.data;
                    csr_pkg::MTVEC:     mtvec           <= write_i.data;
                    csr_pkg::MSCRATCH:  mscratch        <= write_i.data;
                    csr_pkg::MEPC:      mepc            <= write_i.data;
                    csr_pkg::MCAUSE:    mcause          <= write_i.data;
                    csr_pkg::MTVAL:     mtval           <= write_i.data;
                    csr_pkg::MCYCLE:    mcycle[31:0]    <= write_i.data;
                    csr_pkg::MCYCLEH:   mcycle[63:32]   <= write_i.data;
                    csr_pkg::MINSTRET:  minstret[31:0]  <= write_i.data;
                    csr_pkg::MINSTRETH: minstret[63:32] <= write_i.data;
                    default: ;  // Read-only or unmapped
                endcase
            end
        end
    end

    assign state_o = '{
        mstatus:  mstatus,
        misa:     misa,
        mie:      mie,
        mip:      mip_i,
        mtvec:    mtvec,
        mscratch: mscratch,
        mepc:     mepc,
        mcause:   mcause,
        mtval:    mtval,
        mcycle:   mcycle,
        minstret: minstret,
        priv:     priv
    };

endmodule

`default_nettype wire

/* hw/csr_write_arbiter.sv */
// Fixed priority, trap update always wins; the losing CSR write is dropped, never held
`default_nettype none

module csr_write_arbiter (
    input  csr_pkg::csr_write_t   csr_write_i,
    input  csr_pkg::trap_update_t trap_update_i,
    output logic                  grant_trap_o,
    output csr_pkg::trap_update_t update_o,
    output csr_pkg::csr_write_t   write_o
);

    assign grant_trap_o = trap_update_i.valid;

    assign update_o = trap_update_i;

    // CSR instruction only reaches storage when no trap is in flight
    always_comb begin
        write_o       = csr_write_i;
        write_o.valid = csr_write_i.valid && !grant_trap_o;
    end

endmodule

`default_nettype wire

/* hw/irq_unit.sv */
// Interrupt sampling; pending shows two edges after irq_i, cause is held while idle
`default_nettype none

module irq_unit (
    input  logic                clk,
    input  logic                reset,
    input  csr_pkg::csr_word_t  irq_i,
    input  logic                interrupt_ack_i,
    input  csr_pkg::csr_state_t state_i,
    output csr_pkg::csr_word_t  mip_o,
    output logic                irq_pending_o,
    output csr_pkg::irq_code_e  irq_cause_o
);

    csr_pkg::csr_word_t active;
    logic               take_irq;

    assign active   = state_i.mie & mip_o;
    assign take_irq = state_i.mstatus[csr_pkg::MSTATUS_MIE_BIT] && (active != '0)
                      && !interrupt_ack_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            mip_o         <= '0;
            irq_pending_o <= 1'b0;
            irq_cause_o   <= csr_pkg::M_EXT_INT;
        end else begin
            mip_o         <= irq_i;
            irq_pending_o <= take_irq;
            if (take_irq) begin
                if (active[csr_pkg::IRQ_EXT_BIT]) begin
                    irq_cause_o <= csr_pkg::M_EXT_INT;  // Highest priority
                end else if (active[csr_pkg::IRQ_SW_BIT]) begin
                    irq_cause_o <= csr_pkg::M_SW_INT;
                end else if (active[csr_pkg::IRQ_TIM_BIT]) begin
                    irq_cause_o <= csr_pkg::M_TIM_INT;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/trap_unit.sv */
// Trap update former; mret outranks exceptions, exceptions outrank interrupt acknowledge
`default_nettype none

module trap_unit (
    input  csr_pkg::trap_req_t    trap_req_i,
    input  csr_pkg::irq_code_e    irq_cause_i,
    input  csr_pkg::csr_state_t   state_i,
    output csr_pkg::trap_update_t trap_update_o
);

    localparam int MIE  = csr_pkg::MSTATUS_MIE_BIT;
    localparam int MPIE = csr_pkg::MSTATUS_MPIE_BIT;
    localparam int MPP  = csr_pkg::MSTATUS_MPP_LO;

    csr_pkg::csr_word_t entry_status;
    csr_pkg::exc_code_e code;
    logic               at_pc;  // ecall and breakpoint return to the faulting pc

    // mstatus as written on any trap entry
    always_comb begin
        entry_status = state_i.mstatus;
        entry_status[MPP +: 2] = state_i.priv;
        entry_status[MPIE] = state_i.mstatus[MIE];
        entry_status[MIE] = 1'b0;
    end

    assign code  = trap_req_i.exception_code;
    assign at_pc = (code == csr_pkg::ECALL_FROM_MMODE) || (code == csr_pkg::ECALL_FROM_UMODE)
                   || (code == csr_pkg::BREAKPOINT);

    always_comb begin
        trap_update_o             = '0;
        trap_update_o.mstatus     = state_i.mstatus;
        trap_update_o.priv        = state_i.priv;
        trap_update_o.mepc        = state_i.mepc;
        trap_update_o.mcause      = state_i.mcause;
        trap_update_o.mtval       = state_i.mtval;

        if (trap_req_i.machine_return) begin
            trap_update_o.valid            = 1'b1;
            trap_update_o.mstatus[MIE]     = state_i.mstatus[MPIE];
            trap_update_o.priv             = csr_pkg::priv_e'(state_i.mstatus[MPP +: 2]);
        end else if (trap_req_i.raise_exception) begin
            trap_update_o.valid       = 1'b1;
            trap_update_o.mstatus     = entry_status;
            trap_update_o.priv        = csr_pkg::PRIV_MACHINE;
            trap_update_o.load_mepc   = 1'b1;
            trap_update_o.mepc        = at_pc ? trap_req_i.pc : trap_req_i.pc + 32'd4;
            trap_update_o.load_mcause = 1'b1;
            trap_update_o.mcause      = {27'b0, code};  // Top bit clear for exceptions
            trap_update_o.load_mtval  = 1'b1;
            trap_update_o.mtval       = (code == csr_pkg::ILLEGAL_INSTRUCTION)
                                        ? trap_req_i.instruction : trap_req_i.pc;
        end else if (trap_req_i.interrupt_ack) begin
            trap_update_o.valid       = 1'b1;
            trap_update_o.mstatus     = entry_status;
            trap_update_o.priv        = csr_pkg::PRIV_MACHINE;
            trap_update_o.load_mepc   = 1'b1;
            trap_update_o.mepc        = trap_req_i.jump ? trap_req_i.jump_target
                                                        : trap_req_i.pc;
            trap_update_o.load_mcause = 1'b1;
            trap_update_o.mcause      = {1'b1, 26'b0, irq_cause_i};
        end
    end

endmodule

`default_nettype wire

/* hw/csr_op_unit.sv */
// Combinational CSR read and write forming; unknown ops and read-only addresses write nothing
`default_nettype none

module csr_op_unit (
    input  csr_pkg::csr_req_t   csr_req_i,
    input  logic                killed_i,
    input  csr_pkg::csr_state_t state_i,
    output csr_pkg::csr_write_t csr_write_o,
    output csr_pkg::csr_word_t  read_data_o
);

    csr_pkg::csr_addr_e addr;
    csr_pkg::csr_word_t cur_val;
    csr_pkg::csr_word_t wmask;
    csr_pkg::csr_word_t new_val;

    assign addr = csr_pkg::csr_addr_e'(csr_req_i.addr);

    // Current contents, also the read multiplexer
    always_comb begin
        case (addr)
            csr_pkg::MSTATUS:   cur_val = state_i.mstatus;
            csr_pkg::MISA:      cur_val = state_i.misa;
            csr_pkg::MIE:       cur_val = state_i.mie;
            csr_pkg::MTVEC:     cur_val = state_i.mtvec;
            csr_pkg::MSCRATCH:  cur_val = state_i.mscratch;
            csr_pkg::MEPC:      cur_val = state_i.mepc;
            csr_pkg::MCAUSE:    cur_val = state_i.mcause;
            csr_pkg::MTVAL:     cur_val = state_i.mtval;
            csr_pkg::MIP:       cur_val = state_i.mip;
            csr_pkg::MCYCLE,
            csr_pkg::CYCLE:     cur_val = state_i.mcycle[31:0];
            csr_pkg::MCYCLEH,
            csr_pkg::CYCLEH:    cur_val = state_i.mcycle[63:32];
            csr_pkg::MINSTRET,
            csr_pkg::INSTRET:   cur_val = state_i.minstret[31:0];
            csr_pkg::MINSTRETH,
            csr_pkg::INSTRETH:  cur_val = state_i.minstret[63:32];
            default:            cur_val = '0;  // Identity regs and unmapped
        endcase
    end

    always_comb begin
        case (addr)
            csr_pkg::MSTATUS:   wmask = csr_pkg::MSTATUS_MASK;
            csr_pkg::MISA:      wmask = csr_pkg::MISA_MASK;
            csr_pkg::MIE:       wmask = csr_pkg::MIE_MASK;
            csr_pkg::MTVEC:     wmask = csr_pkg::MTVEC_MASK;
            csr_pkg::MEPC:      wmask = csr_pkg::MEPC_MASK;
            csr_pkg::MSCRATCH,
            csr_pkg::MCAUSE,
            csr_pkg::MTVAL,
            csr_pkg::MCYCLE,
            csr_pkg::MCYCLEH,
            csr_pkg::MINSTRET,
            csr_pkg::MINSTRETH: wmask = csr_pkg::ALL_ONES_MASK;
            default:            wmask = '0;  // mip and user aliases are read-only
        endcase
    end

    always_comb begin
        case (csr_req_i.op)
            csr_pkg::WRITE: new_val = csr_req_i.data & wmask;
            csr_pkg::SET:   new_val = (cur_val | csr_req_i.data) & wmask;
            csr_pkg::CLEAR: new_val = (cur_val & ~csr_req_i.data) & wmask;
            default:        new_val = '0;
        endcase
    end

    assign csr_write_o.valid = csr_req_i.write_en && !killed_i
                               && (csr_req_i.op != csr_pkg::NONE);
    assign csr_write_o.addr  = csr_req_i.addr;
    assign csr_write_o.data  = new_val;

    assign read_data_o = (csr_req_i.read_en && !killed_i) ? cur_val : '0;

endmodule

`default_nettype wire

/* hw/csr_pkg.sv */
// Machine-mode CSR definitions for RV32 only; no S-mode, no time CSRs, identity CSRs read zero
`default_nettype none

package csr_pkg;

    typedef logic [31:0] csr_word_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [63:0] csr_count_t;  // mcycle and minstret
    typedef logic [4:0]  cause_code_t;

    typedef enum csr_addr_t {
        MSTATUS    = 12'h300,
        MISA       = 12'h301,
        MIE        = 12'h304,
        MTVEC      = 12'h305,
        MSCRATCH   = 12'h340,
        MEPC       = 12'h341,
        MCAUSE     = 12'h342,
        MTVAL      = 12'h343,
        MIP        = 12'h344,
        MCYCLE     = 12'hB00,
        MINSTRET   = 12'hB02,
        MCYCLEH    = 12'hB80,
        MINSTRETH  = 12'hB82,
        CYCLE      = 12'hC00,  // User read-only aliases
        INSTRET    = 12'hC02,
        CYCLEH     = 12'hC80,
        INSTRETH   = 12'hC82,
        MVENDORID  = 12'hF11,
        MARCHID    = 12'hF12,
        MIMPID     = 12'hF13,
        MHARTID    = 12'hF14,
        MCONFIGPTR = 12'hF15
    } csr_addr_e;

    typedef enum logic [1:0] {
        NONE  = 2'b00,
        WRITE = 2'b01,
        SET   = 2'b10,
        CLEAR = 2'b11
    } csr_op_e;

    // Same encoding as mstatus.MPP
    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_e;

    typedef enum cause_code_t {
        INSTR_MISALIGNED    = 5'd0,
        INSTR_ACCESS_FAULT  = 5'd1,
        ILLEGAL_INSTRUCTION = 5'd2,
        BREAKPOINT          = 5'd3,
        LOAD_MISALIGNED     = 5'd4,
        LOAD_ACCESS_FAULT   = 5'd5,
        STORE_MISALIGNED    = 5'd6,
        STORE_ACCESS_FAULT  = 5'd7,
        ECALL_FROM_UMODE    = 5'd8,
        ECALL_FROM_MMODE    = 5'd11
    } exc_code_e;

    typedef enum cause_code_t {
        M_SW_INT  = 5'd3,
        M_TIM_INT = 5'd7,
        M_EXT_INT = 5'd11
    } irq_code_e;

    localparam csr_word_t MSTATUS_MASK  = 32'h007E19AA;
    localparam csr_word_t MISA_MASK     = 32'h3C000000;
    localparam csr_word_t MIE_MASK      = 32'h00000888;
    localparam csr_word_t MTVEC_MASK    = 32'hFFFFFFFC;
    localparam csr_word_t MEPC_MASK     = 32'hFFFFFFFC;
    localparam csr_word_t ALL_ONES_MASK = 32'hFFFFFFFF;  // mscratch, mcause, mtval, counters
    localparam csr_word_t MISA_RESET    = 32'h40000100;  // RV32I

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LO   = 11;
    localparam int IRQ_SW_BIT       = 3;
    localparam int IRQ_TIM_BIT      = 7;
    localparam int IRQ_EXT_BIT      = 11;

    typedef struct packed {
        logic      read_en;
        logic      write_en;
        csr_op_e   op;
        csr_addr_t addr;
        csr_word_t data;
    } csr_req_t;

    typedef struct packed {
        logic      raise_exception;
        exc_code_e exception_code;
        logic      machine_return;
        logic      interrupt_ack;
        csr_word_t pc;
        csr_word_t instruction;
        logic      jump;
        csr_word_t jump_target;
    } trap_req_t;

    typedef struct packed {
        logic      valid;
        csr_addr_t addr;
        csr_word_t data;
    } csr_write_t;

    typedef struct packed {
        logic      valid;
        csr_word_t mstatus;
        priv_e     priv;
        logic      load_mepc;
        csr_word_t mepc;
        logic      load_mcause;
        csr_word_t mcause;
        logic      load_mtval;
        csr_word_t mtval;
    } trap_update_t;

    typedef struct packed {
        csr_word_t  mstatus;
        csr_word_t  misa;
        csr_word_t  mie;
        csr_word_t  mip;
        csr_word_t  mtvec;
        csr_word_t  mscratch;
        csr_word_t  mepc;
        csr_word_t  mcause;
        csr_word_t  mtval;
        csr_count_t mcycle;
        csr_count_t minstret;
        priv_e      priv;
    } csr_state_t;

endpackage

`default_nettype wire
